//--- logic/recip_pkg.sv
/*
 * reciprocal unit package
 * single-precision float format, result record and pipeline depth
 */

package recip_pkg;

	// --------------------------------------------------
	// float format
	// --------------------------------------------------
	localparam int exp_width = 8;
	localparam int frac_width = 23;
	localparam int exp_bias = 127;

	// pipeline depth, shared by control and datapath
	localparam int stage_count = 5;

	typedef struct packed {
		logic sign;
		logic [exp_width-1:0] exp;
		logic [frac_width-1:0] frac;
	} float_t;

	// value plus divide-by-zero flag
	typedef struct packed {
		float_t value;
		logic div_zero;
	} recip_out_t;

	// --------------------------------------------------
	// special values
	// --------------------------------------------------
	// canonical quiet nan
	localparam float_t qnan = '{
		sign: 1'b0,
		exp: '1,
		frac: frac_width'(1) << (frac_width - 1)
	};

	localparam float_t pos_inf = '{
		sign: 1'b0,
		exp: '1,
		frac: '0
	};

endpackage

//--- logic/skid_buffer.sv
/*
 * two-entry valid/ready skid buffer
 * in_ready comes from a flop, so no ready path crosses the buffer
 */

module skid_buffer #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic rst_n,
	input payload_t in_data,
	input logic in_valid,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid,
	input logic out_ready
);

	payload_t main_data;
	payload_t skid_data;
	logic main_valid;
	logic skid_valid;
	logic in_fire;
	logic main_load;
	logic main_valid_next;
	logic skid_valid_next;

	assign in_fire = in_valid && in_ready;

	// main register free or draining this cycle
	assign main_load = !main_valid || out_ready;

	always_comb begin
		if (main_load) begin
			main_valid_next = skid_valid || in_fire;
			skid_valid_next = 1'b0;
		end else begin
			main_valid_next = 1'b1;
			skid_valid_next = skid_valid || in_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
			in_ready <= 1'b0;
		end else begin
			main_valid <= main_valid_next;
			skid_valid <= skid_valid_next;
			in_ready <= !skid_valid_next;
		end
	end

	always_ff @(posedge clk) begin
		if (main_load) begin
			main_data <= skid_valid ? skid_data : in_data;
		end
		// stalled, park the new item
		if (!main_load && in_fire) begin
			skid_data <= in_data;
		end
	end

	assign out_data = main_data;
	assign out_valid = main_valid;

endmodule

//--- logic/pipe_ctrl.sv
/*
 * pipeline control
 * valid shift register and the one enable shared by all stages
 */

module pipe_ctrl (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	output logic stage_en,
	output logic [recip_pkg::stage_count-1:0] stage_valid,
	output logic out_valid,
	input logic out_ready
);

	import recip_pkg::*;

	logic last_valid;

	assign last_valid = stage_valid[stage_count-1];

	// --------------------------------------------------
	// common enable
	// --------------------------------------------------
	// advance when the last stage is empty or drains
	assign stage_en = !last_valid || out_ready;

	// an item enters whenever the pipe moves
	assign in_ready = stage_en;

	// --------------------------------------------------
	// valid shift register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_valid <= '0;
		end else if (stage_en) begin
			stage_valid <= {stage_valid[stage_count-2:0], in_valid};
		end
	end

	assign out_valid = last_valid;

endmodule

//--- logic/recip_table.sv
/*
 * reciprocal base/gradient table
 * built at elaboration with real arithmetic, read through two registers
 */

module recip_table #(
	parameter int d_width = 8
) (
	input logic clk,
	input logic [1:0] en,
	input logic [d_width-1:0] addr,
	output logic [recip_pkg::frac_width-1:0] base_frac,
	output logic [recip_pkg::frac_width-1:0] grad
);

	import recip_pkg::*;

	localparam int tbl_size = 1 << d_width;

	typedef struct packed {
		logic [frac_width-1:0] base;
		logic [frac_width-1:0] grad;
	} entry_t;

	entry_t mem [tbl_size];
	entry_t rd_q0;
	entry_t rd_q1;

	// --------------------------------------------------
	// table fill
	// --------------------------------------------------
	// value of 2 / (1 + i/2^d) scaled by 2^frac_width, hidden bit removed.
	// entry 0 keeps the carry into bit frac_width, so its field reads zero
	initial begin : fill_table
		real scaled;
		logic [frac_width:0] prev_full;
		logic [frac_width:0] cur_full;

		prev_full = (frac_width + 1)'(1) << frac_width;
		for (int i = 1; i <= tbl_size; i++) begin
			scaled = (2.0 ** (frac_width + 1)) / (1.0 + real'(i) / real'(tbl_size));
			cur_full = (frac_width + 1)'($rtoi(scaled + 0.5) - (1 << frac_width));
			mem[i-1].base = prev_full[frac_width-1:0];
			// slope over one interval
			mem[i-1].grad = frac_width'(prev_full - cur_full);
			prev_full = cur_full;
		end
	end

	// --------------------------------------------------
	// read registers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (en[0]) begin
			rd_q0 <= mem[addr];
		end
		if (en[1]) begin
			rd_q1 <= rd_q0;
		end
	end

	assign base_frac = rd_q1.base;
	assign grad = rd_q1.grad;

endmodule

//--- logic/recip_datapath.sv
/*
 * reciprocal datapath
 * exponent, special cases and table interpolation over five stages
 */

module recip_datapath #(
	parameter int d_width = 8
) (
	input logic clk,
	input logic stage_en,
	input logic [recip_pkg::stage_count-1:0] stage_valid,
	input recip_pkg::float_t in_data,
	output recip_pkg::recip_out_t out_data
);

	import recip_pkg::*;

	localparam int k_width = frac_width - d_width;
	localparam int exp_sum = 2 * exp_bias - 1;

	typedef struct packed {
		logic zero;
		logic inf;
		logic nan;
	} spec_t;

	spec_t in_spec;
	spec_t spec0, spec1, spec2, spec3;
	logic sign0, sign1, sign2, sign3;
	logic [exp_width-1:0] exp0;
	logic frac_zero0;
	// signed range -1 to 254
	logic [exp_width:0] exp1, exp2, exp3;
	logic [k_width-1:0] k0, k1, k2;
	logic [frac_width-1:0] tbl_base, tbl_grad;
	logic [frac_width-1:0] base2, grad2, base3, corr3;
	logic [frac_width+k_width-1:0] prod;
	float_t res;
	recip_out_t out4;

	// classify input
	always_comb begin
		in_spec.zero = (in_data.exp == '0);
		in_spec.inf = (in_data.exp == '1) && (in_data.frac == '0);
		in_spec.nan = (in_data.exp == '1) && (in_data.frac != '0);
	end

	recip_table #(
		.d_width(d_width)
	) table_i (
		.clk(clk),
		.en({2{stage_en}}),
		.addr(in_data.frac[frac_width-1 -: d_width]),
		.base_frac(tbl_base),
		.grad(tbl_grad)
	);

	always_comb begin
		prod = {{k_width{1'b0}}, grad2} * {{frac_width{1'b0}}, k2};
	end

	// --------------------------------------------------
	// stage 4 result select
	// --------------------------------------------------
	always_comb begin
		res.sign = sign3;
		res.exp = exp3[exp_width-1:0];
		res.frac = base3 - corr3;
		if (spec3.nan) begin
			res = qnan;
		end else if (spec3.zero) begin
			res = pos_inf;
			res.sign = sign3;
		end else if (spec3.inf || exp3[exp_width] || (exp3 == '0)) begin
			// infinity or exponent underflow
			res.exp = '0;
			res.frac = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (stage_en) begin
			sign0 <= in_data.sign;
			exp0 <= in_data.exp;
			frac_zero0 <= (in_data.frac == '0);
			k0 <= in_data.frac[k_width-1:0];
			spec0 <= in_spec;

			sign1 <= sign0;
			exp1 <= (exp_width + 1)'(exp_sum) - {1'b0, exp0} + (exp_width + 1)'(frac_zero0);
			k1 <= k0;
			spec1 <= stage_valid[0] ? spec0 : '0;

			sign2 <= sign1;
			exp2 <= exp1;
			k2 <= k1;
			base2 <= tbl_base;
			grad2 <= tbl_grad;
			spec2 <= stage_valid[1] ? spec1 : '0;

			sign3 <= sign2;
			exp3 <= exp2;
			base3 <= base2;
			corr3 <= prod[frac_width+k_width-1 -: frac_width];
			spec3 <= stage_valid[2] ? spec2 : '0;

			out4.value <= res;
			out4.div_zero <= stage_valid[3] && spec3.zero;
		end
	end

	assign out_data = out4;

endmodule

//--- logic/float_recip_top.sv
/*
 * float reciprocal top level
 * input buffer, five-stage pipeline and output buffer
 */

module float_recip_top #(
	parameter int d_width = 8
) (
	input logic clk,
	input logic rst_n,
	input recip_pkg::float_t s_data,
	input logic s_valid,
	output logic s_ready,
	output recip_pkg::recip_out_t m_data,
	output logic m_valid,
	input logic m_ready
);

	import recip_pkg::*;

	float_t pipe_data;
	logic pipe_valid;
	logic pipe_ready;
	logic stage_en;
	logic [stage_count-1:0] stage_valid;
	recip_out_t res_data;
	logic res_valid;
	logic res_ready;

	// --------------------------------------------------
	// input side
	// --------------------------------------------------
	skid_buffer #(
		.payload_t(float_t)
	) in_buf_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(s_data),
		.in_valid(s_valid),
		.in_ready(s_ready),
		.out_data(pipe_data),
		.out_valid(pipe_valid),
		.out_ready(pipe_ready)
	);

	pipe_ctrl pipe_ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(pipe_valid),
		.in_ready(pipe_ready),
		.stage_en(stage_en),
		.stage_valid(stage_valid),
		.out_valid(res_valid),
		.out_ready(res_ready)
	);

	recip_datapath #(
		.d_width(d_width)
	) datapath_i (
		.clk(clk),
		.stage_en(stage_en),
		.stage_valid(stage_valid),
		.in_data(pipe_data),
		.out_data(res_data)
	);

	// output side
	skid_buffer #(
		.payload_t(recip_out_t)
	) out_buf_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(res_data),
		.in_valid(res_valid),
		.in_ready(res_ready),
		.out_data(m_data),
		.out_valid(m_valid),
		.out_ready(m_ready)
	);

endmodule

//--- include/recip_ref.svh
/*
 * reciprocal reference model
 * rebuilds the interpolation table with real arithmetic and applies the result rules
 */

`ifndef recip_ref_svh
`define recip_ref_svh

// full fraction of 2 / (1 + i/2^d), hidden bit removed, entry 0 carries into bit 23
function automatic longint table_full(input int i, input int d);
	real span;
	real scaled;
	span = real'(longint'(1) << d);
	scaled = real'(longint'(1) << (frac_width + 1)) / (1.0 + real'(i) / span);
	return longint'($rtoi(scaled + 0.5)) - (longint'(1) << frac_width);
endfunction

function automatic recip_out_t expected_recip(input float_t x, input int d);
	recip_out_t r;
	int kw;
	int biased;
	longint idx;
	longint k;
	longint grad;
	longint corr;
	kw = frac_width - d;
	r.div_zero = 1'b0;
	r.value.sign = x.sign;
	r.value.exp = '0;
	r.value.frac = '0;
	if (x.exp == '0) begin
		// zero or denormal
		r.value.exp = '1;
		r.div_zero = 1'b1;
	end else if (x.exp == '1 && x.frac != '0) begin
		r.value = float_t'(32'h7fc00000);
	end else if (x.exp != '1) begin
		idx = longint'(x.frac) >> kw;
		k = longint'(x.frac) - (idx << kw);
		biased = 2 * exp_bias - 1 - int'(x.exp) + ((x.frac == '0) ? 1 : 0);
		if (biased > 0) begin
			grad = table_full(int'(idx), d) - table_full(int'(idx) + 1, d);
			corr = (grad * k) >> kw;
			r.value.exp = exp_width'(biased);
			r.value.frac = frac_width'(table_full(int'(idx), d) - corr);
		end
	end
	// infinity and underflow leave the signed zero
	return r;
endfunction

function automatic real float_to_real(input float_t f);
	real v;
	int e;
	v = 1.0 + real'(f.frac) / real'(longint'(1) << frac_width);
	e = int'(f.exp) - exp_bias;
	while (e > 0) begin
		v = v * 2.0;
		e--;
	end
	while (e < 0) begin
		v = v / 2.0;
		e++;
	end
	return f.sign ? -v : v;
endfunction

`endif

//--- sim/float_recip_tb.sv
/*
 * float reciprocal testbench
 * directed, special, random and back-pressure traffic against a reference model
 */

module float_recip_tb;

	import recip_pkg::*;

	localparam int tb_d_width = 8;
	localparam int timeout_cycles = 400;
	localparam logic [31:0] directed_vals [8] = '{
		32'h3f800000, 32'h40000000, 32'h3f000000, 32'h40400000,
		32'h35c00000, 32'hbf800000, 32'hc0400000, 32'h3fffffff
	};
	// zeros, denormals, infinities, nans, exponent 253 and 254
	localparam logic [31:0] special_vals [12] = '{
		32'h00000000, 32'h80000000, 32'h00000001, 32'h807fffff,
		32'h7f800000, 32'hff800000, 32'h7fc00000, 32'hff800001,
		32'h7e800001, 32'hfe923456, 32'h7f000000, 32'hff7fffff
	};

	logic clk;
	logic rst_n;
	float_t s_data;
	logic s_valid;
	logic s_ready;
	recip_out_t m_data;
	logic m_valid;
	logic m_ready;

	float_t in_q[$];
	string name_q[$];
	string cur_test = "reset";
	int ready_mode = 0;
	int stim_seed = 32'h46ac;
	int ready_seed = 32'h46ac;

	`include "recip_ref.svh"

	float_recip_top #(
		.d_width(tb_d_width)
	) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#4;
			clk = ~clk;
		end
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			stop_with_error($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// called 1 unit after an edge and returns 1 unit after the transfer edge
	task automatic send_item(input float_t v);
		int waited;
		waited = 0;
		s_data = v;
		s_valid = 1'b1;
		while (!s_ready) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > timeout_cycles) begin
				stop_with_error("input side stayed not ready, s_ready timed out");
			end
		end
		in_q.push_back(v);
		name_q.push_back(cur_test);
		@(posedge clk);
		#1;
		s_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (in_q.size() != 0) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > timeout_cycles) begin
				stop_with_error("results did not come out of the pipeline in time");
			end
		end
	endtask

	function automatic float_t random_normal();
		float_t f;
		int r;
		int r2;
		r = $random(stim_seed);
		r2 = $random(stim_seed);
		f.sign = r2[31];
		f.exp = exp_width'(1 + $unsigned(r) % 252);
		f.frac = r2[frac_width-1:0];
		return f;
	endfunction

	// --------------------------------------------------
	// output ready patterns
	// --------------------------------------------------
	initial begin : ready_driver
		int stall;
		stall = 0;
		m_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			case (ready_mode)
				0: m_ready = 1'b1;
				1: m_ready = ($random(ready_seed) & 3) != 0;
				default: begin
					// long stall then a short burst
					stall = (stall + 1) % 48;
					m_ready = (stall >= 40);
				end
			endcase
		end
	end

	// --------------------------------------------------
	// result checking
	// --------------------------------------------------
	initial begin : compare_results
		float_t in_v;
		string name;
		recip_out_t exp_r;
		real exact;
		real rel;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				check_value("reset m_valid", 64'(0), 64'(m_valid));
				check_value("reset s_ready", 64'(0), 64'(s_ready));
			end else if (m_valid && m_ready) begin
				if (in_q.size() == 0) begin
					stop_with_error("an output transfer happened with no input outstanding");
				end
				in_v = in_q.pop_front();
				name = name_q.pop_front();
				exp_r = expected_recip(in_v, tb_d_width);
				check_value({name, " value"}, 64'(exp_r.value), 64'(m_data.value));
				check_value({name, " div_zero"}, 64'(exp_r.div_zero), 64'(m_data.div_zero));
				if (exp_r.value.exp != '0 && exp_r.value.exp != '1) begin
					exact = 1.0 / float_to_real(in_v);
					rel = (float_to_real(m_data.value) - exact) / exact;
					if (rel < 0.0) begin
						rel = -rel;
					end
					if (rel > 1.0 / 65536.0) begin
						stop_with_error($sformatf("reciprocal of %h is too far from exact", in_v));
					end
				end
			end
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin : stimulus
		int waited;
		float_t v;
		rst_n = 1'b0;
		s_valid = 1'b0;
		s_data = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		waited = 0;
		while (!s_ready) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > timeout_cycles) begin
				stop_with_error("s_ready never rose after reset");
			end
		end
		cur_test = "directed";
		foreach (directed_vals[j]) send_item(float_t'(directed_vals[j]));
		wait_drain();
		cur_test = "special";
		foreach (special_vals[j]) send_item(float_t'(special_vals[j]));
		cur_test = "random";
		repeat (2000) send_item(random_normal());
		wait_drain();
		cur_test = "backpressure";
		for (int i = 0; i < 1200; i++) begin
			ready_mode = (i < 600) ? 1 : 2;
			v = random_normal();
			// mix in zero, denormal, infinity and nan inputs
			if (i % 16 == 0) begin
				v.exp = '0;
			end else if (i % 16 == 8) begin
				v.exp = '1;
			end
			if (($random(stim_seed) & 7) == 0) begin
				@(posedge clk);
				#1;
			end
			send_item(v);
		end
		ready_mode = 0;
		waited = 0;
		while (in_q.size() != 0 && waited <= timeout_cycles) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (in_q.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_with_error("results were still outstanding when the final drain timed out");
		end
	end

endmodule

//--- verilog.f
+incdir+include
logic/recip_pkg.sv
logic/skid_buffer.sv
logic/pipe_ctrl.sv
logic/recip_table.sv
logic/recip_datapath.sv
logic/float_recip_top.sv
sim/float_recip_tb.sv

//--- Makefile
TOP = float_recip_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module float_recip_top
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

obj_dir/V$(TOP): verilog.f $(wildcard logic/*.sv include/*.svh sim/*.sv)
	verilator --binary --timing -f verilog.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
